// ==== design/ctl_cfg.svh ====
`ifndef CTL_CFG_SVH
`define CTL_CFG_SVH

// Basic widths
`define CTL_OPCODE_W 6
`define CTL_UOP_W 4
`define CTL_WORD_W 32
// Byte address into the store, word index then byte lane
`define CTL_BOOT_ADDR_W 12

// Words in the microcode store, one per opcode and micro-op pair
`define CTL_UCODE_DEPTH 1024

// Micro-ops already in flight when an END is seen
`define CTL_SQUASH 2

// Constant for the control data bus
`define CTL_DATA_MSB 5
`define CTL_DATA_LSB 0
// Register file select
`define CTL_REG_SEL_MSB 7
`define CTL_REG_SEL_LSB 6
// Out plane, in plane and misc plane
`define CTL_OUT_MSB 11
`define CTL_OUT_LSB 8
`define CTL_IN_MSB 14
`define CTL_IN_LSB 12
`define CTL_MISC_BIT 15
// ALU and shifter controls
`define CTL_MLU_MSB 19
`define CTL_MLU_LSB 16
`define CTL_SHIFT_MSB 21
`define CTL_SHIFT_LSB 20
`define CTL_SHIFT_ARITH_BIT 22
// Next opcode source, 1 takes it from the bus
`define CTL_OPSEL_BIT 23

`endif

// ==== design/ctl_pkg.sv ====
`include "ctl_cfg.svh"

package ctl_pkg;

  // Opcode and micro-op index, the two halves of a store address
  typedef logic [`CTL_OPCODE_W-1:0] opcode_t;
  typedef logic [`CTL_UOP_W-1:0] uop_idx_t;

  // Opcode in the upper bits, index in the lower bits
  typedef logic [`CTL_OPCODE_W+`CTL_UOP_W-1:0] ucode_addr_t;

  // One latched microcode word
  typedef logic [`CTL_WORD_W-1:0] ucode_word_t;

  // Bootstrap byte address, byte 0 is the LSB of a word
  typedef logic [`CTL_BOOT_ADDR_W-1:0] boot_addr_t;

  // Load targets, decoded to one-cycle strobes
  typedef enum logic [`CTL_IN_MSB-`CTL_IN_LSB:0] {
    IN_NONE,
    IN_REG,
    IN_TMP0,
    IN_TMP1,
    IN_MMU,
    IN_OPWORD,
    IN_OPCODE
  } in_plane_e;

  // Bus drivers, decoded to active-low enables
  typedef enum logic [`CTL_OUT_MSB-`CTL_OUT_LSB:0] {
    OUT_NONE,
    OUT_REG,
    OUT_TMP0,
    OUT_TMP1,
    OUT_MMU,
    OUT_MLU,
    OUT_SHIFTER,
    OUT_TIMER,
    OUT_CTRL_DATA,
    OUT_OPWORD_IMM
  } out_plane_e;

  // Only code here ends the instruction
  typedef enum logic [0:0] {
    MISC_NONE,
    MISC_END
  } misc_plane_e;

  // Sequencer waits for the store to be loaded
  typedef enum logic {
    SEQ_BOOT,
    SEQ_RUN
  } seq_state_e;

endpackage

// ==== design/uop_sequencer.sv ====
`include "ctl_cfg.svh"

module uop_sequencer (
  input  logic                 n_clk,
  input  logic                 n_rst,
  input  logic                 booted,
  input  logic [7:0]           bus,
  input  ctl_pkg::opcode_t     opword_opcode,
  input  logic                 uop_end,
  input  logic                 opcode_load,
  input  logic                 opcode_from_bus,
  output ctl_pkg::ucode_addr_t ucode_addr,
  output logic                 addr_valid
);

  ctl_pkg::seq_state_e state;
  ctl_pkg::seq_state_e state_next;

  // Current opcode and the index of the issued micro-op
  ctl_pkg::opcode_t  opcode_q;
  ctl_pkg::opcode_t  opcode_src;
  ctl_pkg::uop_idx_t uop_q;
  ctl_pkg::uop_idx_t uop_next;

  // Boot hold, leaves once the store is loaded
  // RUN is kept for the rest of the run
  always_comb begin
    state_next = state;
    if ((state == ctl_pkg::SEQ_BOOT) && booted) begin
      state_next = ctl_pkg::SEQ_RUN;
    end
  end

  // Next opcode comes off the bus or out of the opword
  assign opcode_src = opcode_from_bus ? bus[`CTL_OPCODE_W-1:0] : opword_opcode;

  // Counter step
  // First RUN cycle issues index 0 without advancing
  // END restarts the routine, otherwise wrap from 15 to 0
  always_comb begin
    if (uop_end) begin
      uop_next = '0;
    end else if (addr_valid) begin
      uop_next = uop_q + ctl_pkg::uop_idx_t'(1);
    end else begin
      uop_next = uop_q;
    end
  end

  always_ff @(posedge n_clk or negedge n_rst) begin
    if (!n_rst) begin
      state      <= ctl_pkg::SEQ_BOOT;
      opcode_q   <= '0;
      uop_q      <= '0;
      addr_valid <= 1'b0;
    end else begin
      state <= state_next;
      // Nothing moves until the hold is left
      if (state == ctl_pkg::SEQ_RUN) begin
        uop_q      <= uop_next;
        addr_valid <= 1'b1;
        // Loads on the same edge the counter clears
        if (opcode_load) begin
          opcode_q <= opcode_src;
        end
      end
    end
  end

  // Address is the pair of registers, so it is already registered
  // After an END it points at word 0 of the new opcode
  assign ucode_addr = {opcode_q, uop_q};

endmodule

// ==== design/microcode_store.sv ====
`include "ctl_cfg.svh"

module microcode_store (
  input  logic                 n_clk,
  input  logic                 n_rst,
  input  logic                 boot_we,
  input  ctl_pkg::boot_addr_t  boot_addr,
  input  logic [7:0]           boot_data,
  input  ctl_pkg::ucode_addr_t ucode_addr,
  input  logic                 addr_valid,
  output ctl_pkg::ucode_word_t ucode_word,
  output logic                 word_valid
);

  // Bytes per word and the address bits that pick one
  localparam int LANES  = `CTL_WORD_W / 8;
  localparam int LANE_W = $clog2(LANES);

  // Word array, filled only through the bootstrap port
  ctl_pkg::ucode_word_t mem [`CTL_UCODE_DEPTH];

  // Split of the byte address
  logic [LANE_W-1:0]    boot_lane;
  ctl_pkg::ucode_addr_t boot_word;

  assign boot_lane = boot_addr[LANE_W-1:0];
  assign boot_word = boot_addr[`CTL_BOOT_ADDR_W-1:LANE_W];

  // Byte-lane write
  // One byte per strobe, the rest of the word untouched
  always_ff @(posedge n_clk) begin
    if (boot_we) begin
      for (int b = 0; b < LANES; b++) begin
        if (boot_lane == LANE_W'(b)) begin
          mem[boot_word][b*8 +: 8] <= boot_data;
        end
      end
    end
  end

  // Registered read
  // Word shows up one edge after its address
  always_ff @(posedge n_clk) begin
    if (addr_valid) begin
      ucode_word <= mem[ucode_addr];
    end
  end

  // Valid follows the address by the same edge
  always_ff @(posedge n_clk or negedge n_rst) begin
    if (!n_rst) begin
      word_valid <= 1'b0;
    end else begin
      word_valid <= addr_valid;
    end
  end

endmodule

// ==== design/plane_decoder.sv ====
`include "ctl_cfg.svh"

module plane_decoder (
  input  logic                 n_clk,
  input  logic                 n_rst,
  input  ctl_pkg::ucode_word_t ucode_word,
  input  logic                 word_valid,
  output logic                 uop_end,
  output logic                 opcode_load,
  output logic                 opcode_from_bus,
  output logic [5:0]           ctrl_data,
  output logic [1:0]           reg_sel,
  output logic [3:0]           mlu_plane,
  output logic [1:0]           shifter_plane,
  output logic                 shifter_arith,
  output logic                 reg_in,
  output logic                 tmp0_in,
  output logic                 tmp1_in,
  output logic                 mmu_in,
  output logic                 opword_in,
  output logic                 reg_n_out,
  output logic                 tmp0_n_out,
  output logic                 tmp1_n_out,
  output logic                 mmu_n_out,
  output logic                 mlu_n_out,
  output logic                 shifter_n_out,
  output logic                 timer_n_out,
  output logic                 ctrl_data_n_out,
  output logic                 opword_imm_n_out
);

  // Countdown wide enough to hold the squash depth
  localparam int SQ_W = $clog2(`CTL_SQUASH + 1);
  localparam logic [SQ_W-1:0] SQ_LOAD = SQ_W'(`CTL_SQUASH);

  ctl_pkg::ucode_word_t word_q;
  logic                 valid_q;
  logic [SQ_W-1:0]      squash_q;
  // Slot holds a word that is allowed to act
  logic                 live;

  ctl_pkg::in_plane_e   in_plane;
  ctl_pkg::out_plane_e  out_plane;
  ctl_pkg::misc_plane_e misc_plane;

  // Word latch, payload only
  always_ff @(posedge n_clk) begin
    if (word_valid) begin
      word_q <= ucode_word;
    end
  end

  // Valid flag and squash countdown
  // END loads the depth, each arriving word uses one up
  always_ff @(posedge n_clk or negedge n_rst) begin
    if (!n_rst) begin
      valid_q  <= 1'b0;
      squash_q <= '0;
    end else begin
      valid_q <= word_valid;
      if (uop_end) begin
        squash_q <= SQ_LOAD;
      end else if (word_valid && (squash_q != '0)) begin
        squash_q <= squash_q - 1'b1;
      end
    end
  end

  assign live = valid_q && (squash_q == '0);

  // Dead slots read as all NONE
  assign in_plane = live ? ctl_pkg::in_plane_e'(word_q[`CTL_IN_MSB:`CTL_IN_LSB])
                         : ctl_pkg::IN_NONE;
  assign out_plane = live ? ctl_pkg::out_plane_e'(word_q[`CTL_OUT_MSB:`CTL_OUT_LSB])
                          : ctl_pkg::OUT_NONE;
  assign misc_plane = live ? ctl_pkg::misc_plane_e'(word_q[`CTL_MISC_BIT])
                           : ctl_pkg::MISC_NONE;

  // Back to the sequencer
  assign uop_end         = (misc_plane == ctl_pkg::MISC_END);
  assign opcode_load     = (in_plane == ctl_pkg::IN_OPCODE);
  assign opcode_from_bus = live && word_q[`CTL_OPSEL_BIT];

  // Pass-through fields, zero when dead
  assign ctrl_data     = live ? word_q[`CTL_DATA_MSB:`CTL_DATA_LSB] : '0;
  assign reg_sel       = live ? word_q[`CTL_REG_SEL_MSB:`CTL_REG_SEL_LSB] : '0;
  assign mlu_plane     = live ? word_q[`CTL_MLU_MSB:`CTL_MLU_LSB] : '0;
  assign shifter_plane = live ? word_q[`CTL_SHIFT_MSB:`CTL_SHIFT_LSB] : '0;
  assign shifter_arith = live && word_q[`CTL_SHIFT_ARITH_BIT];

  // In plane, one-hot high strobes
  // Opcode load is handled above
  always_comb begin
    reg_in    = 1'b0;
    tmp0_in   = 1'b0;
    tmp1_in   = 1'b0;
    mmu_in    = 1'b0;
    opword_in = 1'b0;
    case (in_plane)
      ctl_pkg::IN_REG:    reg_in = 1'b1;
      ctl_pkg::IN_TMP0:   tmp0_in = 1'b1;
      ctl_pkg::IN_TMP1:   tmp1_in = 1'b1;
      ctl_pkg::IN_MMU:    mmu_in = 1'b1;
      ctl_pkg::IN_OPWORD: opword_in = 1'b1;
      default: ;
    endcase
  end

  // Out plane, one-hot low enables
  always_comb begin
    reg_n_out        = 1'b1;
    tmp0_n_out       = 1'b1;
    tmp1_n_out       = 1'b1;
    mmu_n_out        = 1'b1;
    mlu_n_out        = 1'b1;
    shifter_n_out    = 1'b1;
    timer_n_out      = 1'b1;
    ctrl_data_n_out  = 1'b1;
    opword_imm_n_out = 1'b1;
    case (out_plane)
      ctl_pkg::OUT_REG:        reg_n_out = 1'b0;
      ctl_pkg::OUT_TMP0:       tmp0_n_out = 1'b0;
      ctl_pkg::OUT_TMP1:       tmp1_n_out = 1'b0;
      ctl_pkg::OUT_MMU:        mmu_n_out = 1'b0;
      ctl_pkg::OUT_MLU:        mlu_n_out = 1'b0;
      ctl_pkg::OUT_SHIFTER:    shifter_n_out = 1'b0;
      ctl_pkg::OUT_TIMER:      timer_n_out = 1'b0;
      ctl_pkg::OUT_CTRL_DATA:  ctrl_data_n_out = 1'b0;
      ctl_pkg::OUT_OPWORD_IMM: opword_imm_n_out = 1'b0;
      default: ;
    endcase
  end

endmodule

// ==== design/control_unit.sv ====
module control_unit (
  input  logic                n_clk,
  input  logic                n_rst,
  input  logic                booted,
  input  logic                boot_we,
  input  ctl_pkg::boot_addr_t boot_addr,
  input  logic [7:0]          boot_data,
  input  logic [7:0]          bus,
  input  ctl_pkg::opcode_t    opword_opcode,
  output logic [5:0]          ctrl_data,
  output logic [1:0]          reg_sel,
  output logic [3:0]          mlu_plane,
  output logic [1:0]          shifter_plane,
  output logic                shifter_arith,
  output logic                reg_in,
  output logic                tmp0_in,
  output logic                tmp1_in,
  output logic                mmu_in,
  output logic                opword_in,
  output logic                reg_n_out,
  output logic                tmp0_n_out,
  output logic                tmp1_n_out,
  output logic                mmu_n_out,
  output logic                mlu_n_out,
  output logic                shifter_n_out,
  output logic                timer_n_out,
  output logic                ctrl_data_n_out,
  output logic                opword_imm_n_out
);

  // Stage 1 to stage 2
  ctl_pkg::ucode_addr_t ucode_addr;
  logic                 addr_valid;
  // Stage 2 to stage 3
  ctl_pkg::ucode_word_t ucode_word;
  logic                 word_valid;
  // Stage 3 back to stage 1
  logic                 uop_end;
  logic                 opcode_load;
  logic                 opcode_from_bus;

  // Opcode, counter, boot hold
  uop_sequencer u_seq (
    .n_clk           (n_clk),
    .n_rst           (n_rst),
    .booted          (booted),
    .bus             (bus),
    .opword_opcode   (opword_opcode),
    .uop_end         (uop_end),
    .opcode_load     (opcode_load),
    .opcode_from_bus (opcode_from_bus),
    .ucode_addr      (ucode_addr),
    .addr_valid      (addr_valid)
  );

  // Writable store
  microcode_store u_store (
    .n_clk      (n_clk),
    .n_rst      (n_rst),
    .boot_we    (boot_we),
    .boot_addr  (boot_addr),
    .boot_data  (boot_data),
    .ucode_addr (ucode_addr),
    .addr_valid (addr_valid),
    .ucode_word (ucode_word),
    .word_valid (word_valid)
  );

  // Word latch and plane decode
  plane_decoder u_dec (
    .n_clk            (n_clk),
    .n_rst            (n_rst),
    .ucode_word       (ucode_word),
    .word_valid       (word_valid),
    .uop_end          (uop_end),
    .opcode_load      (opcode_load),
    .opcode_from_bus  (opcode_from_bus),
    .ctrl_data        (ctrl_data),
    .reg_sel          (reg_sel),
    .mlu_plane        (mlu_plane),
    .shifter_plane    (shifter_plane),
    .shifter_arith    (shifter_arith),
    .reg_in           (reg_in),
    .tmp0_in          (tmp0_in),
    .tmp1_in          (tmp1_in),
    .mmu_in           (mmu_in),
    .opword_in        (opword_in),
    .reg_n_out        (reg_n_out),
    .tmp0_n_out       (tmp0_n_out),
    .tmp1_n_out       (tmp1_n_out),
    .mmu_n_out        (mmu_n_out),
    .mlu_n_out        (mlu_n_out),
    .shifter_n_out    (shifter_n_out),
    .timer_n_out      (timer_n_out),
    .ctrl_data_n_out  (ctrl_data_n_out),
    .opword_imm_n_out (opword_imm_n_out)
  );

endmodule

// ==== tb/control_unit_props.sv ====
module control_unit_props (
  input logic             n_clk,
  input logic             n_rst,
  input logic             booted,
  input logic [7:0]       bus,
  input ctl_pkg::opcode_t opword_opcode,
  input logic [5:0]       ctrl_data,
  input logic [1:0]       reg_sel,
  input logic [3:0]       mlu_plane,
  input logic [1:0]       shifter_plane,
  input logic             shifter_arith,
  input logic             reg_in,
  input logic             tmp0_in,
  input logic             tmp1_in,
  input logic             mmu_in,
  input logic             opword_in,
  input logic             reg_n_out,
  input logic             tmp0_n_out,
  input logic             tmp1_n_out,
  input logic             mmu_n_out,
  input logic             mlu_n_out,
  input logic             shifter_n_out,
  input logic             timer_n_out,
  input logic             ctrl_data_n_out,
  input logic             opword_imm_n_out
);
  timeunit 1ns;
  timeprecision 100ps;

  // Only the timer enable is low on an END word
  localparam logic [8:0] END_ENABLES = 9'b1_1011_1111;

  // Strobes and enables in the order of their plane enums
  logic [4:0]       strobes;
  logic [8:0]       enables_n;
  logic             active;
  logic [4:0]       exp_strobes;
  logic [8:0]       exp_enables_n;
  int               mod6;
  int               mod5;
  // Opcode the END word would load
  ctl_pkg::opcode_t next_op;

  assign strobes   = {opword_in, mmu_in, tmp1_in, tmp0_in, reg_in};
  assign enables_n = {opword_imm_n_out, ctrl_data_n_out, timer_n_out, shifter_n_out,
                      mlu_n_out, mmu_n_out, tmp1_n_out, tmp0_n_out, reg_n_out};
  // Every live word drives some out enable
  assign active    = (enables_n != '1);
  // Opcode bit 0 doubles as the select and sits in reg_sel bit 0
  assign next_op   = reg_sel[0] ? bus[5:0] : opword_opcode;

  // Expected planes from the word index
  always_comb begin
    mod6          = int'(ctrl_data) % 6;
    mod5          = int'(ctrl_data) % 5;
    exp_strobes   = (mod6 == 0) ? 5'b0 : 5'(1 << (mod6 - 1));
    exp_enables_n = ~(9'(1) << mod5);
  end

  // Quiet outputs in reset and boot
  a_boot_quiet: assert property (@(posedge n_clk)
    (!n_rst || !booted) |-> (strobes == '0 && enables_n == '1 && ctrl_data == '0))
    else begin
      $error("** Error at %0t: outputs not quiet during reset or boot", $time);
      control_unit_tb.assert_errors++;
    end

  // Opcode 0 runs first after 4 idle cycles of pipeline fill
  a_first_op: assert property (@(posedge n_clk) disable iff (!n_rst)
    $rose(booted) |-> !active ##1 !active ##1 !active ##1 !active
      ##1 (active && ctrl_data == '0 && reg_sel == '0 && mlu_plane == '0))
    else begin
      $error("** Error at %0t: first micro-op after boot is wrong", $time);
      control_unit_tb.assert_errors++;
    end

  // One-hot planes matching the index
  a_planes: assert property (@(posedge n_clk) disable iff (!n_rst)
    active |-> ($onehot0(strobes) && $onehot0(~enables_n) &&
      (timer_n_out ? (strobes == exp_strobes && enables_n == exp_enables_n)
                   : (strobes == '0 && enables_n == END_ENABLES))))
    else begin
      $error("** Error at %0t: plane decode wrong for index %0d", $time, ctrl_data);
      control_unit_tb.assert_errors++;
    end

  // No image word sets the shifter fields
  a_shifter: assert property (@(posedge n_clk) disable iff (!n_rst)
    (shifter_plane == '0 && !shifter_arith))
    else begin
      $error("** Error at %0t: shifter fields not zero", $time);
      control_unit_tb.assert_errors++;
    end

  // Micro-op index steps inside one instruction
  a_step: assert property (@(posedge n_clk) disable iff (!n_rst)
    (active && timer_n_out) |=> (active && ctrl_data == $past(ctrl_data) + 6'd1 &&
      reg_sel == $past(reg_sel) && mlu_plane == $past(mlu_plane)))
    else begin
      $error("** Error at %0t: micro-op did not step to the next index", $time);
      control_unit_tb.assert_errors++;
    end

  // Two squashed slots before word 0 of the loaded opcode
  a_end: assert property (@(posedge n_clk) disable iff (!n_rst)
    !timer_n_out |=> !active ##1 !active
      ##1 (active && ctrl_data == '0 && {mlu_plane, reg_sel} == $past(next_op, 3)))
    else begin
      $error("** Error at %0t: instruction end not followed by the new opcode", $time);
      control_unit_tb.assert_errors++;
    end

endmodule

// ==== tb/control_unit_tb.sv ====
`include "ctl_cfg.svh"

module control_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PERIOD       = 100;
  localparam int DRIVE_DELAY  = 5;
  localparam int RESET_CYCLES = 4;
  // One bootstrap byte per cycle for the whole store
  localparam int BOOT_BYTES   = `CTL_UCODE_DEPTH * (`CTL_WORD_W / 8);
  localparam int RUN_CYCLES   = 2000;
  localparam int MARGIN       = 50;
  localparam int OPCODES      = 1 << `CTL_OPCODE_W;
  localparam int UOPS         = 1 << `CTL_UOP_W;

  logic                 n_clk;
  logic                 n_rst;
  logic                 booted;
  logic                 boot_we;
  ctl_pkg::boot_addr_t  boot_addr;
  logic [7:0]           boot_data;
  logic [7:0]           bus;
  ctl_pkg::opcode_t     opword_opcode;
  logic [5:0]           ctrl_data;
  logic [1:0]           reg_sel;
  logic [3:0]           mlu_plane;
  logic [1:0]           shifter_plane;
  logic                 shifter_arith;
  logic                 reg_in;
  logic                 tmp0_in;
  logic                 tmp1_in;
  logic                 mmu_in;
  logic                 opword_in;
  logic                 reg_n_out;
  logic                 tmp0_n_out;
  logic                 tmp1_n_out;
  logic                 mmu_n_out;
  logic                 mlu_n_out;
  logic                 shifter_n_out;
  logic                 timer_n_out;
  logic                 ctrl_data_n_out;
  logic                 opword_imm_n_out;

  // Bumped by the bound assertions
  int                   assert_errors;
  int                   other_errors;
  int                   end_count;
  logic [31:0]          rng;
  int                   routine_len [OPCODES];
  ctl_pkg::ucode_word_t image [`CTL_UCODE_DEPTH];

  control_unit DUT (.*);

  bind control_unit control_unit_props u_props (.*);

  always #(PERIOD / 2) n_clk = ~n_clk;

  // Instruction ends seen on the falling edge
  always @(negedge n_clk) begin
    if (booted && !timer_n_out) begin
      end_count++;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Word i of the routine for opcode p
  function automatic ctl_pkg::ucode_word_t image_word(input int p, input int i, input int len);
    ctl_pkg::ucode_word_t w;
    logic [9:0]           a;
    a = 10'((p << `CTL_UOP_W) | i);
    w = '0;
    if (i >= len) begin
      // Filler drives an enable so a slot leaking past the squash is seen
      w[`CTL_OUT_MSB:`CTL_OUT_LSB] = ctl_pkg::OUT_OPWORD_IMM;
      // Spare byte tagged with the address
      w[31:24] = 8'(a ^ (a >> 8));
    end else begin
      w[`CTL_DATA_MSB:`CTL_DATA_LSB]       = 6'(i);
      w[`CTL_REG_SEL_MSB:`CTL_REG_SEL_LSB] = 2'(p);
      w[`CTL_MLU_MSB:`CTL_MLU_LSB]         = 4'(p >> 2);
      if (i == len - 1) begin
        w[`CTL_IN_MSB:`CTL_IN_LSB]   = ctl_pkg::IN_OPCODE;
        w[`CTL_OUT_MSB:`CTL_OUT_LSB] = ctl_pkg::OUT_TIMER;
        w[`CTL_MISC_BIT]             = ctl_pkg::MISC_END;
        // Odd opcodes fetch the next one from the bus
        w[`CTL_OPSEL_BIT]            = a[`CTL_UOP_W];
      end else begin
        w[`CTL_IN_MSB:`CTL_IN_LSB]   = ctl_pkg::in_plane_e'(i % 6);
        w[`CTL_OUT_MSB:`CTL_OUT_LSB] = 4'(int'(ctl_pkg::OUT_REG) + (i % 5));
      end
    end
    return w;
  endfunction

  // Random routine length from 2 to 15 per opcode
  task automatic build_image();
    for (int p = 0; p < OPCODES; p++) begin
      rng = xorshift32(rng);
      routine_len[p] = 2 + int'(rng % 14);
      for (int i = 0; i < UOPS; i++) begin
        image[p * UOPS + i] = image_word(p, i, routine_len[p]);
      end
    end
  endtask

  // Load byte by byte with booted low and release the sequencer
  task automatic load_image();
    for (int a = 0; a < BOOT_BYTES; a++) begin
      @(posedge n_clk);
      #DRIVE_DELAY;
      boot_we   = 1'b1;
      boot_addr = ctl_pkg::boot_addr_t'(a);
      boot_data = image[a / 4][(a % 4) * 8 +: 8];
    end
    @(posedge n_clk);
    #DRIVE_DELAY;
    boot_we = 1'b0;
    booted  = 1'b1;
  endtask

  // Fresh bus and opword values every cycle
  task automatic run_instructions();
    repeat (RUN_CYCLES) begin
      @(posedge n_clk);
      #DRIVE_DELAY;
      rng           = xorshift32(rng);
      bus           = rng[7:0];
      opword_opcode = ctl_pkg::opcode_t'(rng[21:16]);
    end
  endtask

  initial begin
    n_clk         = 1'b0;
    n_rst         = 1'b0;
    booted        = 1'b0;
    boot_we       = 1'b0;
    boot_addr     = '0;
    boot_data     = '0;
    bus           = '0;
    opword_opcode = '0;
    assert_errors = 0;
    other_errors  = 0;
    end_count     = 0;
    rng           = 32'd14;
    build_image();
    repeat (RESET_CYCLES) @(posedge n_clk);
    #DRIVE_DELAY;
    n_rst = 1'b1;
    load_image();
    run_instructions();
    if (end_count == 0) begin
      $display("Stimulus never reached the end of an instruction");
      other_errors++;
    end
    $display("Run done: %0d assertion errors, %0d other errors, %0d instructions ended",
             assert_errors, other_errors, end_count);
    if (assert_errors + other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Reset, boot and run length plus margin
  initial begin
    #((RESET_CYCLES + BOOT_BYTES + RUN_CYCLES + MARGIN) * PERIOD);
    $display("Watchdog expired before the run finished");
    $display("Errors found");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+design
design/ctl_pkg.sv
design/uop_sequencer.sv
design/microcode_store.sv
design/plane_decoder.sv
design/control_unit.sv
tb/control_unit_props.sv
tb/control_unit_tb.sv
